// ==== src.f ====
+incdir+.
lcd_cmd_pkg.sv
lcd_text_pkg.sv
lcd_instr_issuer.sv
lcd_char_writer.sv
lcd_msg_rom.sv
lcd_status_display.sv
tb_lcd_status_display.sv

// ==== Bender.yml ====
package:
  name: lcd_status_display

sources:
  - include_dirs:
      - .
    files:
      - lcd_cmd_pkg.sv
      - lcd_text_pkg.sv
      - lcd_instr_issuer.sv
      - lcd_char_writer.sv
      - lcd_msg_rom.sv
      - lcd_status_display.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_lcd_status_display.sv

// ==== tb_lcd_status_display.sv ====
`timescale 1ns/1ps

`include "lcd_cfg.svh"

module tb_lcd_status_display;
    import lcd_cmd_pkg::*;
    import lcd_text_pkg::*;

    localparam int WRITE_CYC = `LCD_SETUP_CYC + `LCD_EN_HIGH_CYC + `LCD_HOLD_CYC
                               + `LCD_EXEC_CYC + 2;
    localparam int INIT_TIMEOUT   = 4 * (5 * WRITE_CYC + `LCD_CLEAR_EXEC_CYC);
    localparam int RENDER_TIMEOUT = 2 * 34 * WRITE_CYC;
    localparam int NUM_RENDERS    = 20;
    localparam int RENDER_WRITES  = 2 * `LCD_COLS + 2;

    logic       clk;
    logic       rst_n;
    logic       start;
    disp_mode_e mode;
    lcd_byte_t  lcd_data;
    logic       lcd_en;
    logic       lcd_rs;
    logic       lcd_rw;
    logic       init_done;
    logic       render_done;

    integer     seed;
    int         errors;
    int         writes_checked;

    // reference text and first column per mode code
    string     msg_text [8] = '{"Initializing", "Stop", "Play Pause", "Record Pause",
                                "Playing", "Recording", "Recording", "Recording"};
    int        msg_col  [8] = '{2, 6, 3, 2, 3, 3, 3, 3};
    lcd_byte_t init_bytes [5] = '{8'h38, 8'h08, 8'h01, 8'h06, 8'h0C};

    logic [8:0] wr_q[$]; // {rs, data} per finished write
    logic       en_prev = 1'b0;
    logic [8:0] en_word;
    int         en_width;
    int         rdone_cnt;
    int         rdone_writes;

    lcd_status_display i_lcd_status_display (
        .i_clk         (clk),
        .i_rst_n       (rst_n),
        .i_start       (start),
        .i_mode        (mode),
        .o_lcd_data    (lcd_data),
        .o_lcd_en      (lcd_en),
        .o_lcd_rs      (lcd_rs),
        .o_lcd_rw      (lcd_rw),
        .o_init_done   (init_done),
        .o_render_done (render_done)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // bus monitor samples settled outputs at the falling edge
    always @(negedge clk) begin
        if (lcd_rw !== 1'b0) begin
            errors++;
            $display("error rw_low: expected 0, actual %b", lcd_rw);
        end
        if (render_done === 1'b1) begin
            rdone_cnt++;
            rdone_writes = wr_q.size();
        end
        if (lcd_en === 1'b1) begin
            if (!en_prev) begin
                en_word  = {lcd_rs, lcd_data};
                en_width = 1;
            end else begin
                en_width++;
                if ({lcd_rs, lcd_data} !== en_word) begin
                    errors++;
                    $display("error bus_stable: expected %h, actual %h", en_word,
                             {lcd_rs, lcd_data});
                end
            end
        end else if (en_prev) begin
            if (en_width != `LCD_EN_HIGH_CYC) begin
                errors++;
                $display("error en_width: expected %0d, actual %0d", `LCD_EN_HIGH_CYC,
                         en_width);
            end
            wr_q.push_back(en_word);
        end
        en_prev = (lcd_en === 1'b1);
    end

    function automatic lcd_byte_t model_char(logic [2:0] code, int idx);
        int col;
        col = msg_col[code];
        if (idx >= `LCD_COLS || idx < col || idx - col >= msg_text[code].len())
            return 8'h20;
        return msg_text[code][idx - col];
    endfunction

    function automatic logic [8:0] model_write(logic [2:0] code, int k);
        if (k == 0)
            return {1'b0, 8'h80};
        if (k == `LCD_COLS + 1)
            return {1'b0, 8'h80 | {1'b0, `LCD_LINE1_ADDR}}; // second line address
        if (k <= `LCD_COLS)
            return {1'b1, model_char(code, k - 1)};
        return {1'b1, model_char(code, k - 2)};
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("errors: %0d before the run was stopped", errors);
        $display("SOME TESTS FAILED");
        $finish;
    endtask

    task automatic wait_init_done();
        int n;
        n = 0;
        while (init_done !== 1'b1) begin
            @(negedge clk);
            n++;
            if (n > INIT_TIMEOUT)
                abort_run("timeout: init done flag never went high");
        end
    endtask

    task automatic wait_render_count(input int target);
        int n;
        n = 0;
        while (rdone_cnt < target) begin
            @(posedge clk); // count moves on falling edges only
            n++;
            if (n > RENDER_TIMEOUT)
                abort_run("timeout: render done pulse never came");
        end
    endtask

    initial begin
        int         r;
        logic [2:0] code;
        logic [2:0] base;
        seed  = 32'hb665_a538;
        rst_n = 1'b0;
        start = 1'b0;
        mode  = MODE_INIT;
        repeat (10) @(negedge clk);
        if (lcd_en !== 1'b0 || init_done !== 1'b0 || render_done !== 1'b0) begin
            errors++;
            $display("error reset_low: expected 000, actual %b%b%b", lcd_en, init_done,
                     render_done);
        end
        rst_n = 1'b1;

        wait_init_done();
        if (wr_q.size() != 5) begin
            errors++;
            $display("error init_count: expected 5, actual %0d", wr_q.size());
        end
        for (int k = 0; k < 5 && k < wr_q.size(); k++) begin
            if (wr_q[k] !== {1'b0, init_bytes[k]}) begin
                errors++;
                $display("error init write %0d: expected %h, actual %h", k,
                         {1'b0, init_bytes[k]}, wr_q[k]);
            end
        end
        wr_q.delete();

        r    = $random(seed);
        base = r[2:0];
        for (int i = 0; i < NUM_RENDERS; i++) begin
            r    = $random(seed);
            code = (i < 8) ? 3'(i) + base : r[2:0]; // first eight hit every code
            @(negedge clk);
            start = 1'b0;
            repeat (1 + r[7:3]) @(negedge clk);
            mode  = disp_mode_e'(code);
            start = 1'b1;
            if (r[8]) begin
                // new edge and new mode while the screen is being written
                repeat (50 + r[17:9]) @(negedge clk);
                start = 1'b0;
                mode  = disp_mode_e'(~code);
                @(negedge clk);
                start = 1'b1;
            end
            wait_render_count(i + 1);
            repeat (3) @(negedge clk);
            if (rdone_cnt != i + 1 || rdone_writes != RENDER_WRITES) begin
                errors++;
                $display("error render %0d done: expected 1 after %0d, actual %0d after %0d",
                         i, RENDER_WRITES, rdone_cnt - i, rdone_writes);
            end
            if (init_done !== 1'b1) begin
                errors++;
                $display("error init_done_hold: expected 1, actual %b", init_done);
            end
            if (wr_q.size() != RENDER_WRITES) begin
                errors++;
                $display("error render %0d count: expected %0d, actual %0d", i,
                         RENDER_WRITES, wr_q.size());
            end
            for (int k = 0; k < RENDER_WRITES && k < wr_q.size(); k++) begin
                writes_checked++;
                if (wr_q[k] !== model_write(code, k)) begin
                    errors++;
                    $display("error render %0d write %0d: expected %h, actual %h", i, k,
                             model_write(code, k), wr_q[k]);
                end
            end
            wr_q.delete();
            repeat (WRITE_CYC + r[21:18]) @(negedge clk); // start still high in idle
            if (wr_q.size() != 0 || rdone_cnt != i + 1) begin
                errors++;
                $display("held start level began another render after render %0d", i);
            end
        end

        $display("errors: %0d, renders: %0d, writes checked: %0d", errors, NUM_RENDERS,
                 writes_checked);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== lcd_status_display.sv ====
`timescale 1ns/1ps

`include "lcd_cfg.svh"

module lcd_status_display (
    input  logic                     i_clk,
    input  logic                     i_rst_n,
    input  logic                     i_start,
    input  lcd_text_pkg::disp_mode_e i_mode,
    output lcd_cmd_pkg::lcd_byte_t   o_lcd_data,
    output logic                     o_lcd_en,
    output logic                     o_lcd_rs,
    output logic                     o_lcd_rw,
    output logic                     o_init_done,
    output logic                     o_render_done
);
    import lcd_cmd_pkg::*;
    import lcd_text_pkg::*;

    typedef enum logic [2:0] {
        ST_BOOT,
        ST_INIT,
        ST_IDLE,
        ST_SET_ADDR,
        ST_WRITE
    } state_e;

    state_e      state;
    logic [2:0]  instr_idx;
    char_idx_t   char_idx;
    disp_mode_e  mode_q;
    logic        start_d;
    logic        start_rise;
    logic        init_done_q;
    logic        render_done_q;

    // issuer side
    logic        inst_start;
    instr_e      inst_kind;
    ddram_addr_t inst_addr;
    logic        inst_done;
    lcd_byte_t   ins_data;
    logic        ins_en;
    logic        ins_rs;
    logic        ins_rw;

    // writer side
    logic        char_start;
    char_t       rom_char;
    logic        char_done;
    lcd_byte_t   wr_data;
    logic        wr_en;
    logic        wr_rs;
    logic        wr_rw;

    logic        use_instr;

    assign start_rise = i_start & ~start_d;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state         <= ST_BOOT;
            instr_idx     <= '0;
            char_idx      <= '0;
            mode_q        <= MODE_INIT;
            start_d       <= 1'b0;
            inst_start    <= 1'b0;
            inst_kind     <= FUNC_SET;
            inst_addr     <= '0;
            char_start    <= 1'b0;
            init_done_q   <= 1'b0;
            render_done_q <= 1'b0;
        end else begin
            start_d       <= i_start;
            inst_start    <= 1'b0; // strobes default low
            char_start    <= 1'b0;
            render_done_q <= 1'b0;
            case (state)
                ST_BOOT: begin
                    instr_idx  <= '0;
                    inst_kind  <= FUNC_SET;
                    inst_start <= 1'b1;
                    state      <= ST_INIT;
                end
                ST_INIT: begin
                    if (inst_done) begin
                        if (instr_idx == INIT_COUNT - 3'd1) begin
                            init_done_q <= 1'b1;
                            state       <= ST_IDLE;
                        end else begin
                            instr_idx  <= instr_idx + 3'd1;
                            inst_kind  <= instr_e'(instr_idx + 3'd1); // list is enum order
                            inst_start <= 1'b1;
                        end
                    end
                end
                ST_IDLE: begin
                    if (start_rise) begin
                        mode_q     <= i_mode; // held for the whole screen
                        char_idx   <= '0;
                        inst_kind  <= SET_DDRAM;
                        inst_addr  <= '0;
                        inst_start <= 1'b1;
                        state      <= ST_SET_ADDR;
                    end
                end
                ST_SET_ADDR: begin
                    if (inst_done) begin
                        char_start <= 1'b1;
                        state      <= ST_WRITE;
                    end
                end
                ST_WRITE: begin
                    if (char_done) begin
                        if (char_idx == char_idx_t'(2 * `LCD_COLS - 1)) begin
                            render_done_q <= 1'b1;
                            state         <= ST_IDLE;
                        end else if (char_idx == char_idx_t'(`LCD_COLS - 1)) begin
                            char_idx   <= char_idx + 1'b1;
                            inst_kind  <= SET_DDRAM;
                            inst_addr  <= `LCD_LINE1_ADDR;
                            inst_start <= 1'b1;
                            state      <= ST_SET_ADDR;
                        end else begin
                            char_idx   <= char_idx + 1'b1;
                            char_start <= 1'b1;
                        end
                    end
                end
                default: state <= ST_BOOT;
            endcase
        end
    end

    lcd_instr_issuer u_issuer (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_start    (inst_start),
        .i_kind     (inst_kind),
        .i_addr     (inst_addr),
        .o_lcd_data (ins_data),
        .o_lcd_en   (ins_en),
        .o_lcd_rs   (ins_rs),
        .o_lcd_rw   (ins_rw),
        .o_done     (inst_done)
    );

    lcd_char_writer u_char_writer (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_start    (char_start),
        .i_char     (rom_char),
        .o_lcd_data (wr_data),
        .o_lcd_en   (wr_en),
        .o_lcd_rs   (wr_rs),
        .o_lcd_rw   (wr_rw),
        .o_done     (char_done)
    );

    lcd_msg_rom u_msg_rom (
        .i_mode (mode_q),
        .i_idx  (char_idx),
        .o_char (rom_char)
    );

    // pins follow whichever block owns the current state
    assign use_instr = (state == ST_BOOT) || (state == ST_INIT) || (state == ST_SET_ADDR);

    assign o_lcd_data    = use_instr ? ins_data : wr_data;
    assign o_lcd_en      = use_instr ? ins_en : wr_en;
    assign o_lcd_rs      = use_instr ? ins_rs : wr_rs;
    assign o_lcd_rw      = use_instr ? ins_rw : wr_rw;
    assign o_init_done   = init_done_q;
    assign o_render_done = render_done_q;

endmodule

// ==== lcd_msg_rom.sv ====
`timescale 1ns/1ps

`include "lcd_cfg.svh"

module lcd_msg_rom (
    input  lcd_text_pkg::disp_mode_e i_mode,
    input  lcd_text_pkg::char_idx_t  i_idx,
    output lcd_text_pkg::char_t      o_char
);
    import lcd_text_pkg::*;

    localparam int LINE_W = `LCD_COLS * 8;

    // first line of each message with the leftmost column in the top byte
    localparam logic [LINE_W-1:0] MSG_INIT       = "  Initializing  ";
    localparam logic [LINE_W-1:0] MSG_STOP       = "      Stop      ";
    localparam logic [LINE_W-1:0] MSG_PLAY_PAUSE = "   Play Pause   ";
    localparam logic [LINE_W-1:0] MSG_REC_PAUSE  = "  Record Pause  ";
    localparam logic [LINE_W-1:0] MSG_PLAYING    = "   Playing      ";
    localparam logic [LINE_W-1:0] MSG_RECORDING  = "   Recording    ";

    localparam char_t SPACE = 8'h20;

    logic [LINE_W-1:0] line0;
    logic [3:0]        col;

    always_comb begin
        case (i_mode)
            MODE_INIT:       line0 = MSG_INIT;
            MODE_STOP:       line0 = MSG_STOP;
            MODE_PLAY_PAUSE: line0 = MSG_PLAY_PAUSE;
            MODE_REC_PAUSE:  line0 = MSG_REC_PAUSE;
            MODE_PLAYING:    line0 = MSG_PLAYING;
            default:         line0 = MSG_RECORDING; // also codes 6, 7
        endcase
    end

    assign col = i_idx[3:0];

    // second line stays blank for every mode
    assign o_char = i_idx[4] ? SPACE : line0[8 * (4'd15 - col) +: 8];

endmodule

// ==== lcd_char_writer.sv ====
`timescale 1ns/1ps

`include "lcd_cfg.svh"

module lcd_char_writer (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  logic                   i_start,
    input  lcd_text_pkg::char_t    i_char,
    output lcd_cmd_pkg::lcd_byte_t o_lcd_data,
    output logic                   o_lcd_en,
    output logic                   o_lcd_rs,
    output logic                   o_lcd_rw,
    output logic                   o_done
);
    import lcd_cmd_pkg::*;
    import lcd_text_pkg::*;

    localparam int CNT_W = $clog2(`LCD_EXEC_CYC);

    bus_phase_e       phase;
    logic [CNT_W-1:0] cnt;
    logic [CNT_W-1:0] phase_last;
    char_t            char_q;
    logic             done_q;

    always_ff @(posedge i_clk) begin
        if (i_start && phase == PH_IDLE) char_q <= i_char;
    end

    always_comb begin
        case (phase)
            PH_SETUP: phase_last = CNT_W'(`LCD_SETUP_CYC - 1);
            PH_EN:    phase_last = CNT_W'(`LCD_EN_HIGH_CYC - 1);
            PH_HOLD:  phase_last = CNT_W'(`LCD_HOLD_CYC - 1);
            default:  phase_last = CNT_W'(`LCD_EXEC_CYC - 1);
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            phase  <= PH_IDLE;
            cnt    <= '0;
            done_q <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (phase == PH_IDLE) begin
                if (i_start) begin
                    phase <= PH_SETUP;
                    cnt   <= '0;
                end
            end else if (cnt == phase_last) begin
                cnt <= '0;
                case (phase)
                    PH_SETUP: phase <= PH_EN;
                    PH_EN:    phase <= PH_HOLD;
                    PH_HOLD:  phase <= PH_EXEC;
                    default: begin
                        phase  <= PH_IDLE;
                        done_q <= 1'b1;
                    end
                endcase
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    assign o_lcd_data = (phase == PH_IDLE) ? '0 : char_q;
    assign o_lcd_en   = (phase == PH_EN);
    assign o_lcd_rs   = (phase != PH_IDLE); // data register while busy
    assign o_lcd_rw   = 1'b0;
    assign o_done     = done_q;

endmodule

// ==== lcd_instr_issuer.sv ====
`timescale 1ns/1ps

`include "lcd_cfg.svh"

module lcd_instr_issuer (
    input  logic                     i_clk,
    input  logic                     i_rst_n,
    input  logic                     i_start,
    input  lcd_cmd_pkg::instr_e      i_kind,
    input  lcd_cmd_pkg::ddram_addr_t i_addr,
    output lcd_cmd_pkg::lcd_byte_t   o_lcd_data,
    output logic                     o_lcd_en,
    output logic                     o_lcd_rs,
    output logic                     o_lcd_rw,
    output logic                     o_done
);
    import lcd_cmd_pkg::*;

    localparam int CNT_W = $clog2(`LCD_CLEAR_EXEC_CYC);

    bus_phase_e       phase;
    logic [CNT_W-1:0] cnt;
    logic [CNT_W-1:0] phase_last;
    lcd_byte_t        cmd_q;
    logic             is_clear_q;
    logic             done_q;

    function automatic lcd_byte_t encode(instr_e kind, ddram_addr_t addr);
        lcd_byte_t b;
        case (kind)
            FUNC_SET:   b = 8'h38; // 8-bit bus, 2 lines, 5x8
            DISP_OFF:   b = 8'h08;
            CLEAR:      b = 8'h01;
            ENTRY_MODE: b = 8'h06; // increment, no shift
            DISP_ON:    b = 8'h0C; // cursor off
            SET_DDRAM:  b = {1'b1, addr};
            default:    b = 8'h00;
        endcase
        return b;
    endfunction

    // command byte and wait length captured with the start strobe
    always_ff @(posedge i_clk) begin
        if (i_start && phase == PH_IDLE) begin
            cmd_q      <= encode(i_kind, i_addr);
            is_clear_q <= (i_kind == CLEAR);
        end
    end

    always_comb begin
        case (phase)
            PH_SETUP: phase_last = CNT_W'(`LCD_SETUP_CYC - 1);
            PH_EN:    phase_last = CNT_W'(`LCD_EN_HIGH_CYC - 1);
            PH_HOLD:  phase_last = CNT_W'(`LCD_HOLD_CYC - 1);
            PH_EXEC:  phase_last = is_clear_q ? CNT_W'(`LCD_CLEAR_EXEC_CYC - 1)
                                              : CNT_W'(`LCD_EXEC_CYC - 1);
            default:  phase_last = '0;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            phase  <= PH_IDLE;
            cnt    <= '0;
            done_q <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (phase == PH_IDLE) begin
                if (i_start) begin
                    phase <= PH_SETUP;
                    cnt   <= '0;
                end
            end else if (cnt == phase_last) begin
                cnt <= '0;
                case (phase)
                    PH_SETUP: phase <= PH_EN;
                    PH_EN:    phase <= PH_HOLD;
                    PH_HOLD:  phase <= PH_EXEC;
                    default: begin
                        phase  <= PH_IDLE;
                        done_q <= 1'b1; // exec wait over
                    end
                endcase
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    assign o_lcd_data = (phase == PH_IDLE) ? '0 : cmd_q;
    assign o_lcd_en   = (phase == PH_EN);
    assign o_lcd_rs   = 1'b0; // instruction register
    assign o_lcd_rw   = 1'b0;
    assign o_done     = done_q;

endmodule

// ==== lcd_text_pkg.sv ====
package lcd_text_pkg;

    // status shown on the front panel
    typedef enum logic [2:0] {
        MODE_INIT       = 3'd0,
        MODE_STOP       = 3'd1,
        MODE_PLAY_PAUSE = 3'd2,
        MODE_REC_PAUSE  = 3'd3,
        MODE_PLAYING    = 3'd4,
        MODE_RECORDING  = 3'd5
    } disp_mode_e; // 6 and 7 render as recording

    typedef logic [7:0] char_t; // ascii as in the hd44780 cgrom for printables

    // screen position where bit 4 selects the line
    typedef logic [4:0] char_idx_t;

endpackage

// ==== lcd_cmd_pkg.sv ====
package lcd_cmd_pkg;

    typedef logic [7:0] lcd_byte_t;
    typedef logic [6:0] ddram_addr_t;

    // power-up order follows the enum order with SET_DDRAM last
    typedef enum logic [2:0] {
        FUNC_SET   = 3'd0, // 0x38
        DISP_OFF   = 3'd1, // 0x08
        CLEAR      = 3'd2, // 0x01 with long exec
        ENTRY_MODE = 3'd3, // 0x06
        DISP_ON    = 3'd4, // 0x0C
        SET_DDRAM  = 3'd5  // 0x80 | addr
    } instr_e;

    localparam logic [2:0] INIT_COUNT = 3'd5;

    // phases of one timed bus write in issuer and char writer
    typedef enum logic [2:0] {
        PH_IDLE,
        PH_SETUP,
        PH_EN,
        PH_HOLD,
        PH_EXEC
    } bus_phase_e;

endpackage

// ==== lcd_cfg.svh ====
`ifndef LCD_CFG_SVH
`define LCD_CFG_SVH

// bus write phases in i_clk cycles
`define LCD_SETUP_CYC 2
`define LCD_EN_HIGH_CYC 12
`define LCD_HOLD_CYC 2

// execution waits after a write
`define LCD_EXEC_CYC 40
`define LCD_CLEAR_EXEC_CYC 200

// screen geometry
`define LCD_COLS 16
`define LCD_LINE1_ADDR 7'h40 // ddram start of second line

`endif
